/* stbuf_consts.svh */
/*
 * Store buffer sizing constants
 * Entry count, line width, address width and the widths derived from them
 */
`ifndef STBUF_CONSTS_SVH
`define STBUF_CONSTS_SVH

// Number of entries, also the sender's initial credit count
`define STBUF_ENTRIES 4

// Line data width in bits
`define STBUF_LINE_W 128

// Physical address width
`define STBUF_PADDR_W 32

// ------------------------------------------------------------------------
// Derived widths
// ------------------------------------------------------------------------
`define STBUF_STRB_W (`STBUF_LINE_W / 8)
`define STBUF_OFS_W $clog2(`STBUF_STRB_W)
`define STBUF_LINE_ADDR_W (`STBUF_PADDR_W - `STBUF_OFS_W)

`endif

/* stbuf_pkg.sv */
/*
 * Store buffer types
 * Entry state encoding, entry record and L1D request payloads
 */
`default_nettype none
`include "stbuf_consts.svh"

package stbuf_pkg;

  typedef logic [`STBUF_LINE_ADDR_W-1:0] stbuf_line_t;  // Address above byte offset
  typedef logic [`STBUF_LINE_W-1:0]      stbuf_data_t;
  typedef logic [`STBUF_STRB_W-1:0]      stbuf_strb_t;

  // Per-entry request sequence
  typedef enum logic [2:0] {
    IDLE,
    RD_L1D,       // Waiting for the read port
    RESP_L1D,     // Read issued, response next cycle
    L1D_UPDATE,   // Line present, writing bytes
    REFILL_REQ,   // Miss, asking for a refill
    WAIT_REFILL,
    WAIT_FINISH   // Written, waiting to be released
  } stbuf_state_t;

  typedef struct packed {
    logic        valid;
    stbuf_line_t line;
    stbuf_data_t data;
    stbuf_strb_t strb;
  } stbuf_entry_t;

  // L1D read carries only the line
  typedef struct packed {
    stbuf_line_t line;
  } stbuf_rd_req_t;

  typedef struct packed {
    stbuf_line_t line;
    stbuf_data_t data;
    stbuf_strb_t strb;
  } stbuf_wr_req_t;

endpackage

`default_nettype wire

/* stbuf_entry.sv */
/*
 * Store buffer entry
 * Holds one line of merged store bytes and steps through the
 * read, refill and write sequence toward the L1D
 */
`timescale 1ns/1ps
`default_nettype none
`include "stbuf_consts.svh"

module stbuf_entry
  import stbuf_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // Store side
  input  logic                      i_load,
  input  logic                      i_merge,
  input  logic [`STBUF_PADDR_W-1:0] i_st_paddr,
  input  stbuf_data_t               i_st_data,
  input  stbuf_strb_t               i_st_strb,
  // L1D read
  input  logic                      i_rd_granted,
  input  logic                      i_resp,
  input  logic                      i_l1d_rd_miss,
  input  logic                      i_l1d_rd_conflict,
  // L1D write
  input  logic                      i_wr_granted,
  input  logic                      i_l1d_wr_conflict,
  // Refill
  input  logic                      i_refill_granted,
  input  logic                      i_refill_done,
  input  logic [`STBUF_PADDR_W-1:0] i_refill_paddr,
  input  logic                      i_finish_accepted,
  output stbuf_entry_t              o_entry,
  output logic                      o_mergeable,
  output logic                      o_rd_req,
  output logic                      o_wr_req,
  output logic                      o_refill_req,
  output logic                      o_finish
);

  stbuf_state_t r_state;
  stbuf_state_t w_state_next;
  stbuf_line_t  r_line;
  stbuf_data_t  r_data;
  stbuf_strb_t  r_strb;
  logic         w_refill_hit;

  // Refill broadcast for our line
  assign w_refill_hit = i_refill_done &
                        (i_refill_paddr[`STBUF_PADDR_W-1:`STBUF_OFS_W] == r_line);

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      IDLE: begin
        if (i_load) w_state_next = RD_L1D;
      end
      RD_L1D: begin
        if (i_rd_granted) w_state_next = RESP_L1D;
      end
      RESP_L1D: begin
        if (i_resp) begin
          if (i_l1d_rd_miss) begin
            w_state_next = REFILL_REQ;
          end else if (i_l1d_rd_conflict) begin
            w_state_next = RD_L1D;  // Replay
          end else begin
            w_state_next = L1D_UPDATE;
          end
        end
      end
      L1D_UPDATE: begin
        if (i_wr_granted) w_state_next = i_l1d_wr_conflict ? RD_L1D : WAIT_FINISH;
      end
      REFILL_REQ: begin
        // Line may already have come in for another entry
        if (w_refill_hit) begin
          w_state_next = RD_L1D;
        end else if (i_refill_granted) begin
          w_state_next = WAIT_REFILL;
        end
      end
      WAIT_REFILL: begin
        if (w_refill_hit) w_state_next = RD_L1D;
      end
      WAIT_FINISH: begin
        if (i_finish_accepted) w_state_next = IDLE;
      end
      default: w_state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  // ------------------------------------------------------------------------
  // Line data, loaded whole or merged byte by byte
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_line <= i_st_paddr[`STBUF_PADDR_W-1:`STBUF_OFS_W];
      r_data <= i_st_data;
      r_strb <= i_st_strb;
    end else if (i_merge) begin
      for (int b = 0; b < `STBUF_STRB_W; b++) begin
        if (i_st_strb[b]) r_data[b*8 +: 8] <= i_st_data[b*8 +: 8];  // Newest wins
      end
      r_strb <= r_strb | i_st_strb;
    end
  end

  assign o_entry = '{valid: (r_state != IDLE), line: r_line, data: r_data, strb: r_strb};

  // No merging once the write may be in flight
  assign o_mergeable  = (r_state != IDLE) && (r_state != L1D_UPDATE) &&
                        (r_state != WAIT_FINISH);
  assign o_rd_req     = (r_state == RD_L1D);
  assign o_wr_req     = (r_state == L1D_UPDATE);
  assign o_refill_req = (r_state == REFILL_REQ);
  assign o_finish     = (r_state == WAIT_FINISH);

endmodule

`default_nettype wire

/* stbuf_ctrl.sv */
/*
 * Store buffer control
 * Allocation and merge selection, read response routing,
 * finish selection and store credit return
 */
`timescale 1ns/1ps
`default_nettype none
`include "stbuf_consts.svh"

module stbuf_ctrl
  import stbuf_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_st_valid,
  input  logic [`STBUF_PADDR_W-1:0] i_st_paddr,
  input  logic [`STBUF_ENTRIES-1:0] i_entry_valids,
  input  logic [`STBUF_ENTRIES-1:0] i_entry_mergeable,
  input  stbuf_line_t               i_entry_lines [`STBUF_ENTRIES],
  input  logic [`STBUF_ENTRIES-1:0] i_entry_finish,
  input  logic [`STBUF_ENTRIES-1:0] i_rd_grant_oh,
  input  logic                      i_rd_fire,
  output logic [`STBUF_ENTRIES-1:0] o_load_oh,
  output logic [`STBUF_ENTRIES-1:0] o_merge_oh,
  output logic [`STBUF_ENTRIES-1:0] o_resp_oh,
  output logic [`STBUF_ENTRIES-1:0] o_finish_oh,
  output logic                      o_st_credit
);

  localparam int unsigned CNT_W = $clog2(`STBUF_ENTRIES) + 1;

  logic [`STBUF_ENTRIES-1:0] w_line_match;
  logic [`STBUF_ENTRIES-1:0] w_merge_cand;
  logic [`STBUF_ENTRIES-1:0] w_free;
  logic [`STBUF_ENTRIES-1:0] r_resp_oh;
  logic                      w_merge_now;
  logic                      w_finish_fire;
  logic [CNT_W-1:0]          r_pend_cnt;
  logic [CNT_W-1:0]          w_pool;

  // ------------------------------------------------------------------------
  // Merge or allocate
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `STBUF_ENTRIES; i++) begin
      w_line_match[i] = (i_entry_lines[i] == i_st_paddr[`STBUF_PADDR_W-1:`STBUF_OFS_W]);
    end
  end

  assign w_merge_cand = i_entry_mergeable & w_line_match;
  assign w_free       = ~i_entry_valids;
  assign w_merge_now  = i_st_valid & (|w_merge_cand);

  // Lowest set bit picks the entry
  assign o_merge_oh = w_merge_now ? (w_merge_cand & (~w_merge_cand + 1'b1)) : '0;
  assign o_load_oh  = (i_st_valid && !(|w_merge_cand)) ? (w_free & (~w_free + 1'b1)) : '0;

  // Response arrives one cycle after the read transfer
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_oh <= '0;
    end else begin
      r_resp_oh <= i_rd_fire ? i_rd_grant_oh : '0;
    end
  end

  assign o_resp_oh = r_resp_oh;

  // ------------------------------------------------------------------------
  // Finish and credits
  // ------------------------------------------------------------------------
  assign o_finish_oh   = i_entry_finish & (~i_entry_finish + 1'b1);
  assign w_finish_fire = |i_entry_finish;

  // Merge credits wait behind a freed-entry credit
  assign w_pool      = r_pend_cnt + CNT_W'(w_merge_now);
  assign o_st_credit = w_finish_fire | (w_pool != '0);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pend_cnt <= '0;
    end else begin
      r_pend_cnt <= w_pool - CNT_W'(!w_finish_fire && (w_pool != '0));
    end
  end

endmodule

`default_nettype wire

/* stbuf_req_arb.sv */
/*
 * Round-robin request arbiter
 * Picks one requester and forwards its payload to a valid/ready port
 */
`timescale 1ns/1ps
`default_nettype none

module stbuf_req_arb #(
  parameter type         payload_t = logic,
  parameter int unsigned N         = 4
) (
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic [N-1:0] i_req,
  input  payload_t     i_payload [N],
  input  logic         i_ready,
  output logic         o_valid,
  output payload_t     o_payload,
  output logic [N-1:0] o_grant_oh
);

  localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [IDX_W-1:0] r_ptr;
  logic [IDX_W-1:0] w_win;
  logic             w_found;

  // Scan from the pointer, first requester wins
  always_comb begin
    w_win   = r_ptr;
    w_found = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (!w_found && i_req[(int'(r_ptr) + k) % N]) begin
        w_found = 1'b1;
        w_win   = IDX_W'((int'(r_ptr) + k) % N);
      end
    end
  end

  always_comb begin
    o_grant_oh        = '0;
    o_grant_oh[w_win] = w_found;
  end

  assign o_valid   = w_found;
  assign o_payload = i_payload[w_win];

  // Move past the winner on a transfer
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else if (o_valid && i_ready) begin
      r_ptr <= (w_win == IDX_W'(N - 1)) ? '0 : w_win + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* stbuf_fwd.sv */
/*
 * Load forwarding
 * Matches the load line against all entries and collects their bytes
 */
`timescale 1ns/1ps
`default_nettype none
`include "stbuf_consts.svh"

module stbuf_fwd
  import stbuf_pkg::*;
(
  input  logic                      i_fwd_valid,
  input  logic [`STBUF_PADDR_W-1:0] i_fwd_paddr,
  input  stbuf_entry_t              i_entries [`STBUF_ENTRIES],
  output logic                      o_fwd_hit,
  output stbuf_data_t               o_fwd_data,
  output stbuf_strb_t               o_fwd_strb
);

  logic [`STBUF_ENTRIES-1:0] w_hit;

  always_comb begin
    o_fwd_data = '0;
    o_fwd_strb = '0;
    for (int e = 0; e < `STBUF_ENTRIES; e++) begin
      w_hit[e] = i_fwd_valid & i_entries[e].valid &
                 (i_entries[e].line == i_fwd_paddr[`STBUF_PADDR_W-1:`STBUF_OFS_W]);
      if (w_hit[e]) begin
        o_fwd_strb = o_fwd_strb | i_entries[e].strb;
        for (int b = 0; b < `STBUF_STRB_W; b++) begin
          // Only strobed bytes contribute
          if (i_entries[e].strb[b]) begin
            o_fwd_data[b*8 +: 8] = o_fwd_data[b*8 +: 8] | i_entries[e].data[b*8 +: 8];
          end
        end
      end
    end
  end

  assign o_fwd_hit = |w_hit;

endmodule

`default_nettype wire

/* stbuf_top.sv */
/*
 * Store buffer top level
 * Store input register, control, entry array, L1D read and write
 * arbiters, refill request pick and load forwarding
 */
`timescale 1ns/1ps
`default_nettype none
`include "stbuf_consts.svh"

module stbuf_top
  import stbuf_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // Store input, credit based
  input  logic                      i_st_valid,
  input  logic [`STBUF_PADDR_W-1:0] i_st_paddr,
  input  stbuf_data_t               i_st_data,
  input  stbuf_strb_t               i_st_strb,
  output logic                      o_st_credit,
  // L1D read
  output logic                      o_l1d_rd_valid,
  output logic [`STBUF_PADDR_W-1:0] o_l1d_rd_paddr,
  input  logic                      i_l1d_rd_ready,
  input  logic                      i_l1d_rd_miss,
  input  logic                      i_l1d_rd_conflict,
  // L1D write
  output logic                      o_l1d_wr_valid,
  output logic [`STBUF_PADDR_W-1:0] o_l1d_wr_paddr,
  output stbuf_data_t               o_l1d_wr_data,
  output stbuf_strb_t               o_l1d_wr_strb,
  input  logic                      i_l1d_wr_conflict,
  // Refill
  output logic                      o_refill_valid,
  output logic [`STBUF_PADDR_W-1:0] o_refill_paddr,
  input  logic                      i_refill_ready,
  input  logic                      i_refill_done,
  input  logic [`STBUF_PADDR_W-1:0] i_refill_paddr,
  // Load forwarding
  input  logic                      i_fwd_valid,
  input  logic [`STBUF_PADDR_W-1:0] i_fwd_paddr,
  output logic                      o_fwd_hit,
  output stbuf_data_t               o_fwd_data,
  output stbuf_strb_t               o_fwd_strb
);

  logic                      r_st_valid;
  logic [`STBUF_PADDR_W-1:0] r_st_paddr;
  stbuf_data_t               r_st_data;
  stbuf_strb_t               r_st_strb;
  stbuf_entry_t              w_entries [`STBUF_ENTRIES];
  stbuf_line_t               w_lines [`STBUF_ENTRIES];
  stbuf_rd_req_t             w_rd_pl [`STBUF_ENTRIES];
  stbuf_wr_req_t             w_wr_pl [`STBUF_ENTRIES];
  stbuf_rd_req_t             w_rd_sel;
  stbuf_wr_req_t             w_wr_sel;
  stbuf_line_t               w_refill_line;
  logic [`STBUF_ENTRIES-1:0] w_valids;
  logic [`STBUF_ENTRIES-1:0] w_mergeable;
  logic [`STBUF_ENTRIES-1:0] w_rd_req;
  logic [`STBUF_ENTRIES-1:0] w_wr_req;
  logic [`STBUF_ENTRIES-1:0] w_refill_req;
  logic [`STBUF_ENTRIES-1:0] w_finish;
  logic [`STBUF_ENTRIES-1:0] w_load_oh;
  logic [`STBUF_ENTRIES-1:0] w_merge_oh;
  logic [`STBUF_ENTRIES-1:0] w_resp_oh;
  logic [`STBUF_ENTRIES-1:0] w_finish_oh;
  logic [`STBUF_ENTRIES-1:0] w_rd_grant_oh;
  logic [`STBUF_ENTRIES-1:0] w_wr_grant_oh;
  logic [`STBUF_ENTRIES-1:0] w_refill_oh;
  logic                      w_rd_fire;

  // Accepted store is registered before merge/allocate
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_st_valid <= 1'b0;
    end else begin
      r_st_valid <= i_st_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_st_paddr <= i_st_paddr;
    r_st_data  <= i_st_data;
    r_st_strb  <= i_st_strb;
  end

  stbuf_ctrl u_ctrl (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_st_valid        (r_st_valid),
    .i_st_paddr        (r_st_paddr),
    .i_entry_valids    (w_valids),
    .i_entry_mergeable (w_mergeable),
    .i_entry_lines     (w_lines),
    .i_entry_finish    (w_finish),
    .i_rd_grant_oh     (w_rd_grant_oh),
    .i_rd_fire         (w_rd_fire),
    .o_load_oh         (w_load_oh),
    .o_merge_oh        (w_merge_oh),
    .o_resp_oh         (w_resp_oh),
    .o_finish_oh       (w_finish_oh),
    .o_st_credit       (o_st_credit)
  );

  // ------------------------------------------------------------------------
  // Entry array
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < `STBUF_ENTRIES; i++) begin : g_entry
    stbuf_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_load            (w_load_oh[i]),
      .i_merge           (w_merge_oh[i]),
      .i_st_paddr        (r_st_paddr),
      .i_st_data         (r_st_data),
      .i_st_strb         (r_st_strb),
      .i_rd_granted      (w_rd_grant_oh[i] & i_l1d_rd_ready),
      .i_resp            (w_resp_oh[i]),
      .i_l1d_rd_miss     (i_l1d_rd_miss),
      .i_l1d_rd_conflict (i_l1d_rd_conflict),
      .i_wr_granted      (w_wr_grant_oh[i]),
      .i_l1d_wr_conflict (i_l1d_wr_conflict),
      .i_refill_granted  (w_refill_oh[i] & i_refill_ready),
      .i_refill_done     (i_refill_done),
      .i_refill_paddr    (i_refill_paddr),
      .i_finish_accepted (w_finish_oh[i]),
      .o_entry           (w_entries[i]),
      .o_mergeable       (w_mergeable[i]),
      .o_rd_req          (w_rd_req[i]),
      .o_wr_req          (w_wr_req[i]),
      .o_refill_req      (w_refill_req[i]),
      .o_finish          (w_finish[i])
    );

    assign w_valids[i] = w_entries[i].valid;
    assign w_lines[i]  = w_entries[i].line;
    assign w_rd_pl[i]  = '{line: w_entries[i].line};
    assign w_wr_pl[i]  = '{line: w_entries[i].line, data: w_entries[i].data,
                           strb: w_entries[i].strb};
  end

  // ------------------------------------------------------------------------
  // L1D read and write ports
  // ------------------------------------------------------------------------
  stbuf_req_arb #(.payload_t(stbuf_rd_req_t), .N(`STBUF_ENTRIES)) u_rd_arb (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_req      (w_rd_req),
    .i_payload  (w_rd_pl),
    .i_ready    (i_l1d_rd_ready),
    .o_valid    (o_l1d_rd_valid),
    .o_payload  (w_rd_sel),
    .o_grant_oh (w_rd_grant_oh)
  );

  assign w_rd_fire      = o_l1d_rd_valid & i_l1d_rd_ready;
  assign o_l1d_rd_paddr = {w_rd_sel.line, {`STBUF_OFS_W{1'b0}}};

  // Write always completes, a conflict sends the entry back to read
  stbuf_req_arb #(.payload_t(stbuf_wr_req_t), .N(`STBUF_ENTRIES)) u_wr_arb (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_req      (w_wr_req),
    .i_payload  (w_wr_pl),
    .i_ready    (1'b1),
    .o_valid    (o_l1d_wr_valid),
    .o_payload  (w_wr_sel),
    .o_grant_oh (w_wr_grant_oh)
  );

  assign o_l1d_wr_paddr = {w_wr_sel.line, {`STBUF_OFS_W{1'b0}}};
  assign o_l1d_wr_data  = w_wr_sel.data;
  assign o_l1d_wr_strb  = w_wr_sel.strb;

  // Refill request, lowest requesting entry
  assign w_refill_oh = w_refill_req & (~w_refill_req + 1'b1);

  always_comb begin
    w_refill_line = '0;
    for (int i = 0; i < `STBUF_ENTRIES; i++) begin
      if (w_refill_oh[i]) w_refill_line = w_refill_line | w_lines[i];
    end
  end

  assign o_refill_valid = |w_refill_req;
  assign o_refill_paddr = {w_refill_line, {`STBUF_OFS_W{1'b0}}};

  stbuf_fwd u_fwd (
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_paddr (i_fwd_paddr),
    .i_entries   (w_entries),
    .o_fwd_hit   (o_fwd_hit),
    .o_fwd_data  (o_fwd_data),
    .o_fwd_strb  (o_fwd_strb)
  );

endmodule

`default_nettype wire

/* tb_stbuf.sv */
/*
 * Store buffer testbench
 * Clock and reset, L1D and refill models, store bursts checked against
 * a per-line byte image, forwarding checks and the closing report
 */
`timescale 1ns/1ps
`default_nettype none
`include "stbuf_consts.svh"

module tb_stbuf
  import stbuf_pkg::*;
();

  localparam int NE          = `STBUF_ENTRIES;
  localparam int NL          = 8;                        // Lines the stimulus uses
  localparam int NUM_PHASES  = 12;
  localparam int TIMEOUT_CYC = (NUM_PHASES + 2) * 130 + 180;
  localparam stbuf_line_t LINE_BASE = 'h00A_5C10;

  logic                      i_clk;
  logic                      i_reset_n;
  logic                      st_valid;
  logic [`STBUF_PADDR_W-1:0] st_paddr;
  stbuf_data_t               st_data;
  stbuf_strb_t               st_strb;
  logic                      st_credit;
  logic                      l1d_rd_valid;
  logic [`STBUF_PADDR_W-1:0] l1d_rd_paddr;
  logic                      l1d_rd_ready;
  logic                      l1d_rd_miss;
  logic                      l1d_rd_conflict;
  logic                      l1d_wr_valid;
  logic [`STBUF_PADDR_W-1:0] l1d_wr_paddr;
  stbuf_data_t               l1d_wr_data;
  stbuf_strb_t               l1d_wr_strb;
  logic                      l1d_wr_conflict;
  logic                      refill_valid;
  logic [`STBUF_PADDR_W-1:0] refill_paddr;
  logic                      refill_ready;
  logic                      refill_done;
  logic [`STBUF_PADDR_W-1:0] done_paddr;
  logic                      fwd_valid;
  logic [`STBUF_PADDR_W-1:0] fwd_paddr;
  logic                      fwd_hit;
  stbuf_data_t               fwd_data;
  stbuf_strb_t               fwd_strb;

  // Reference model with one slot per test line
  stbuf_data_t buf_data [NL];   // Bytes currently held in the buffer
  stbuf_strb_t buf_strb [NL];
  logic        present [NL];    // L1D holds the line
  logic        miss_pend [NL];
  logic        need_rd [NL];    // Read owed after a conflict or miss
  logic        wrote [NL];
  logic        used [NL];
  int          wr_count [NL];

  integer      seed;
  int          errors;
  int          checks;
  int          credits_ret;
  int          credits_spent;
  int          cycle;
  int          fwd_pin;
  logic        early_seen;
  logic        resp_now;
  int          resp_idx;
  int          refill_q [$];
  int          refill_due [$];
  logic        st_d_valid;
  int          st_d_idx;
  stbuf_data_t st_d_data;
  stbuf_strb_t st_d_strb;

  stbuf_top stbuf_top_i (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_st_valid        (st_valid),
    .i_st_paddr        (st_paddr),
    .i_st_data         (st_data),
    .i_st_strb         (st_strb),
    .o_st_credit       (st_credit),
    .o_l1d_rd_valid    (l1d_rd_valid),
    .o_l1d_rd_paddr    (l1d_rd_paddr),
    .i_l1d_rd_ready    (l1d_rd_ready),
    .i_l1d_rd_miss     (l1d_rd_miss),
    .i_l1d_rd_conflict (l1d_rd_conflict),
    .o_l1d_wr_valid    (l1d_wr_valid),
    .o_l1d_wr_paddr    (l1d_wr_paddr),
    .o_l1d_wr_data     (l1d_wr_data),
    .o_l1d_wr_strb     (l1d_wr_strb),
    .i_l1d_wr_conflict (l1d_wr_conflict),
    .o_refill_valid    (refill_valid),
    .o_refill_paddr    (refill_paddr),
    .i_refill_ready    (refill_ready),
    .i_refill_done     (refill_done),
    .i_refill_paddr    (done_paddr),
    .i_fwd_valid       (fwd_valid),
    .i_fwd_paddr       (fwd_paddr),
    .o_fwd_hit         (fwd_hit),
    .o_fwd_data        (fwd_data),
    .o_fwd_strb        (fwd_strb)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic int line_idx(input logic [`STBUF_PADDR_W-1:0] paddr);
    stbuf_line_t line;
    line = paddr[`STBUF_PADDR_W-1:`STBUF_OFS_W];
    return int'(line - LINE_BASE);
  endfunction

  function automatic logic [`STBUF_PADDR_W-1:0] line_paddr(input int idx);
    return {LINE_BASE + stbuf_line_t'(idx), {`STBUF_OFS_W{1'b0}}};
  endfunction

  function automatic logic in_range(input int idx);
    return (idx >= 0) && (idx < NL);
  endfunction

  function automatic stbuf_data_t byte_mask(input stbuf_strb_t strb);
    stbuf_data_t m;
    for (int b = 0; b < `STBUF_STRB_W; b++) begin
      m[b*8 +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  task automatic value_error(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    errors++;
    $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic plain_error(input string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    assert (got === exp) else value_error(name, got, exp);
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else plain_error(msg);
  endtask

  // ------------------------------------------------------------------------
  // Monitor and model update at each rising edge
  // ------------------------------------------------------------------------
  always @(posedge i_clk) begin : monitor
    int idx;
    int avail;
    if (i_reset_n) begin
      avail = NE + credits_ret - credits_spent;
      check_true(avail >= 0 && avail <= NE, "sender credit count out of range");
      if (resp_now) begin  // Response the L1D model drove this cycle
        if (l1d_rd_miss) begin
          miss_pend[resp_idx] = 1'b1;
          need_rd[resp_idx]   = 1'b1;
        end else if (l1d_rd_conflict) begin
          need_rd[resp_idx] = 1'b1;
        end
      end
      resp_now = 1'b0;
      if (l1d_rd_valid && l1d_rd_ready) begin
        idx = line_idx(l1d_rd_paddr);
        check_true(in_range(idx), "L1D read outside the test lines");
        if (in_range(idx)) begin
          check_true(!miss_pend[idx], "line read again before its refill completed");
          need_rd[idx] = 1'b0;
          resp_now     = 1'b1;
          resp_idx     = idx;
        end
      end
      if (refill_valid && refill_ready) begin
        idx = line_idx(refill_paddr);
        check_true(in_range(idx) && miss_pend[idx], "refill request for a line that did not miss");
        if (in_range(idx)) begin
          refill_q.push_back(idx);
          refill_due.push_back(cycle + 4);  // Fixed refill latency
        end
      end
      if (refill_done) begin
        idx            = line_idx(done_paddr);
        miss_pend[idx] = 1'b0;
        present[idx]   = 1'b1;
      end
      if (l1d_wr_valid) begin
        idx = line_idx(l1d_wr_paddr);
        check_true(in_range(idx), "L1D write outside the test lines");
        if (in_range(idx)) begin
          check_true(present[idx], "write to a line the L1D does not hold");
          check_true(!need_rd[idx], "write without a read after a conflict or miss");
          check_val("o_l1d_wr_strb", l1d_wr_strb, buf_strb[idx]);
          check_val("o_l1d_wr_data", l1d_wr_data & byte_mask(buf_strb[idx]), buf_data[idx]);
          if (l1d_wr_conflict) begin
            need_rd[idx] = 1'b1;
          end else begin
            wr_count[idx]++;
            wrote[idx] = 1'b1;
          end
        end
      end
      if (fwd_valid) begin
        idx = line_idx(fwd_paddr);
        // Written lines are left unchecked until their release
        if (in_range(idx) && !wrote[idx]) begin
          check_val("o_fwd_hit", fwd_hit, buf_strb[idx] != '0);
          check_val("o_fwd_strb", fwd_strb, buf_strb[idx]);
          check_val("o_fwd_data", fwd_data, buf_data[idx]);
          if (st_credit && fwd_hit && buf_strb[idx] != '0) early_seen = 1'b1;
        end
      end
      // Store accepted last edge is in its entry from now on
      if (st_d_valid) begin
        for (int b = 0; b < `STBUF_STRB_W; b++) begin
          if (st_d_strb[b]) buf_data[st_d_idx][b*8 +: 8] = st_d_data[b*8 +: 8];
        end
        buf_strb[st_d_idx] = buf_strb[st_d_idx] | st_d_strb;
      end
      st_d_valid = st_valid;
      st_d_idx   = line_idx(st_paddr);
      st_d_data  = st_data;
      st_d_strb  = st_strb;
      if (st_credit) credits_ret++;
    end
    cycle++;
    if (cycle >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the stores did not drain", cycle);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // One cycle of the L1D and refill models on the falling edge
  task automatic step();
    @(negedge i_clk);
    st_valid        = 1'b0;
    l1d_rd_ready    = ($random(seed) & 3) != 0;
    refill_ready    = ($random(seed) & 1) != 0;
    l1d_wr_conflict = ($random(seed) & 7) == 0;
    l1d_rd_miss     = 1'b0;
    l1d_rd_conflict = 1'b0;
    if (resp_now) begin
      if (!present[resp_idx]) l1d_rd_miss = 1'b1;
      else l1d_rd_conflict = ($random(seed) & 3) == 0;
    end
    refill_done = 1'b0;
    if (refill_q.size() > 0 && cycle >= refill_due[0]) begin
      refill_done = 1'b1;
      done_paddr  = line_paddr(refill_q.pop_front());
      void'(refill_due.pop_front());
    end
    fwd_valid = 1'b1;
    fwd_paddr = line_paddr((fwd_pin >= 0) ? fwd_pin : ($random(seed) & 7)) +
                ($random(seed) & 15);
  endtask

  task automatic issue_burst(input int idx, input int len);
    // Whole burst goes back to back so every store after the first merges
    while (NE + credits_ret - credits_spent < len) step();
    for (int k = 0; k < len; k++) begin
      step();
      st_valid = 1'b1;
      st_paddr = line_paddr(idx) + ($random(seed) & 15);
      st_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      st_strb  = stbuf_strb_t'($random(seed));
      if (st_strb == '0) st_strb = 16'h0001;
      credits_spent++;
    end
    used[idx] = 1'b1;
  endtask

  task automatic drain_and_check();
    while (NE + credits_ret - credits_spent != NE) step();
    for (int i = 0; i < NL; i++) begin
      if (used[i]) begin
        check_true(wr_count[i] == 1,
                   $sformatf("line %0d written %0d times instead of once", i, wr_count[i]));
      end
      check_true(!miss_pend[i], "miss left without a completed refill");
      buf_data[i] = '0;
      buf_strb[i] = '0;
      wrote[i]    = 1'b0;
      used[i]     = 1'b0;
      need_rd[i]  = 1'b0;
      wr_count[i] = 0;
      present[i]  = ($random(seed) & 3) != 0;  // Random eviction
    end
    // Freed lines must not forward any more
    for (int i = 0; i < NL; i++) begin
      step();
      fwd_valid = 1'b1;
      fwd_paddr = line_paddr(i);
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin : stimulus
    int nb;
    int start;
    seed            = 46610;
    errors          = 0;
    checks          = 0;
    credits_ret     = 0;
    credits_spent   = 0;
    cycle           = 0;
    fwd_pin         = -1;
    early_seen      = 1'b0;
    resp_now        = 1'b0;
    resp_idx        = 0;
    st_d_valid      = 1'b0;
    st_d_idx        = 0;
    st_d_data       = '0;
    st_d_strb       = '0;
    st_valid        = 1'b0;
    st_paddr        = '0;
    st_data         = '0;
    st_strb         = '0;
    l1d_rd_ready    = 1'b0;
    l1d_rd_miss     = 1'b0;
    l1d_rd_conflict = 1'b0;
    l1d_wr_conflict = 1'b0;
    refill_ready    = 1'b0;
    refill_done     = 1'b0;
    done_paddr      = '0;
    fwd_valid       = 1'b0;
    fwd_paddr       = '0;
    for (int i = 0; i < NL; i++) begin
      buf_data[i]  = '0;
      buf_strb[i]  = '0;
      present[i]   = (i < 4);
      miss_pend[i] = 1'b0;
      need_rd[i]   = 1'b0;
      wrote[i]     = 1'b0;
      used[i]      = 1'b0;
      wr_count[i]  = 0;
    end
    i_reset_n = 1'b0;
    repeat (5) @(negedge i_clk);
    i_reset_n = 1'b1;

    // Two stores to one line while loads watch that line
    fwd_pin = 0;
    issue_burst(0, 2);
    drain_and_check();
    fwd_pin = -1;
    check_true(early_seen, "no early credit for the merged store");

    present[5] = 1'b0;  // Evicted line takes the refill path
    issue_burst(5, 1);
    drain_and_check();

    for (int p = 0; p < NUM_PHASES; p++) begin
      nb    = 2 + ($random(seed) & 3);
      start = $random(seed) & 7;
      for (int k = 0; k < nb; k++) begin
        issue_burst((start + k) % NL, 1 + ($random(seed) & 3) % 3);
      end
      drain_and_check();
    end

    check_true(NE + credits_ret - credits_spent == NE, "sender credits did not return");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
stbuf_pkg.sv
stbuf_entry.sv
stbuf_ctrl.sv
stbuf_req_arb.sv
stbuf_fwd.sv
stbuf_top.sv
tb_stbuf.sv

/* Bender.yml */
package:
  name: stbuf

export_include_dirs:
  - .

sources:
  - stbuf_pkg.sv
  - stbuf_entry.sv
  - stbuf_ctrl.sv
  - stbuf_req_arb.sv
  - stbuf_fwd.sv
  - stbuf_top.sv
  - target: test
    files:
      - tb_stbuf.sv
